//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = cpu_tb
FILELIST = files.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
+incdir+verification
src/cpu_pkg.sv
src/fetch_unit.sv
src/register_file.sv
src/decode_unit.sv
src/hazard_unit.sv
src/execute_unit.sv
src/mem_wb_unit.sv
src/cpu_top.sv
verification/cpu_tb.sv

//--- src/cpu_pkg.sv
package cpu_pkg;

	typedef logic [15:0] word_t;
	typedef logic [1:0] reg_idx_t;

	// one instruction word seen through two field layouts
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			reg_idx_t   rs;
			reg_idx_t   rt;
			reg_idx_t   rd;
			logic [5:0] func;
		} r;
		struct packed {
			logic [3:0] opcode;
			reg_idx_t   rs;
			reg_idx_t   rt;
			logic [7:0] imm;
		} i;
	} instr_u;

	// opcodes
	localparam logic [3:0] op_adi   = 4'd4;
	localparam logic [3:0] op_ori   = 4'd5;
	localparam logic [3:0] op_lhi   = 4'd6;
	localparam logic [3:0] op_lwd   = 4'd7;
	localparam logic [3:0] op_swd   = 4'd8;
	localparam logic [3:0] op_rtype = 4'd15;

	// r-type function field
	localparam logic [5:0] fn_add = 6'd0;
	localparam logic [5:0] fn_sub = 6'd1;
	localparam logic [5:0] fn_and = 6'd2;
	localparam logic [5:0] fn_orr = 6'd3;
	localparam logic [5:0] fn_wwd = 6'd28;
	localparam logic [5:0] fn_hlt = 6'd29;

	localparam logic [1:0] alu_add = 2'd0;
	localparam logic [1:0] alu_sub = 2'd1;
	localparam logic [1:0] alu_and = 2'd2;
	localparam logic [1:0] alu_or  = 2'd3;

	// operand source for execute
	localparam logic [1:0] fwd_reg = 2'd0;
	localparam logic [1:0] fwd_mem = 2'd1;
	localparam logic [1:0] fwd_wb  = 2'd2;

endpackage

//--- src/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
	parameter cpu_pkg::word_t reset_pc = 16'h0000
) (
	input  logic           clk,
	input  logic           reset_n,
	output logic           inst_read_o,
	output cpu_pkg::word_t inst_addr_o,
	input  cpu_pkg::word_t inst_data_i,
	output logic           data_read_o,
	output logic           data_write_o,
	output cpu_pkg::word_t data_addr_o,
	output cpu_pkg::word_t data_wdata_o,
	input  cpu_pkg::word_t data_rdata_i,
	output logic           out_valid_o,
	output cpu_pkg::word_t out_data_o,
	output cpu_pkg::word_t num_inst_o,
	output logic           is_halted_o
);

	logic stall;
	logic halt_seen;
	cpu_pkg::word_t if_instr;
	logic if_valid;

	cpu_pkg::word_t ex_a;
	cpu_pkg::word_t ex_b;
	cpu_pkg::word_t ex_imm;
	cpu_pkg::reg_idx_t ex_rs;
	cpu_pkg::reg_idx_t ex_rt;
	cpu_pkg::reg_idx_t ex_dst;
	logic ex_reg_write;
	logic ex_mem_read;
	logic ex_mem_write;
	logic ex_use_imm;
	logic ex_wwd;
	logic ex_hlt;
	logic [1:0] ex_alu_op;
	cpu_pkg::reg_idx_t id_rs;
	cpu_pkg::reg_idx_t id_rt;
	logic [1:0] fwd_a;
	logic [1:0] fwd_b;

	cpu_pkg::word_t mem_result;
	cpu_pkg::word_t mem_store;
	cpu_pkg::reg_idx_t mem_dst;
	logic mem_reg_write;
	logic mem_read;
	logic mem_write;
	logic mem_wwd;
	logic mem_hlt;

	logic wb_en;
	cpu_pkg::reg_idx_t wb_idx;
	cpu_pkg::word_t wb_data;

	fetch_unit #(
		.reset_pc (reset_pc)
	) u_fetch (
		.clk         (clk),
		.reset_n     (reset_n),
		.stall_i     (stall),
		.halt_seen_i (halt_seen),
		.inst_data_i (inst_data_i),
		.inst_read_o (inst_read_o),
		.inst_addr_o (inst_addr_o),
		.if_instr_o  (if_instr),
		.if_valid_o  (if_valid)
	);

	decode_unit u_decode (
		.clk            (clk),
		.reset_n        (reset_n),
		.stall_i        (stall),
		.if_valid_i     (if_valid),
		.wb_en_i        (wb_en),
		.if_instr_i     (if_instr),
		.wb_idx_i       (wb_idx),
		.wb_data_i      (wb_data),
		.halt_seen_o    (halt_seen),
		.ex_a_o         (ex_a),
		.ex_b_o         (ex_b),
		.ex_imm_o       (ex_imm),
		.ex_rs_o        (ex_rs),
		.ex_rt_o        (ex_rt),
		.ex_dst_o       (ex_dst),
		.ex_reg_write_o (ex_reg_write),
		.ex_mem_read_o  (ex_mem_read),
		.ex_mem_write_o (ex_mem_write),
		.ex_use_imm_o   (ex_use_imm),
		.ex_wwd_o       (ex_wwd),
		.ex_hlt_o       (ex_hlt),
		.ex_alu_op_o    (ex_alu_op),
		.id_rs_o        (id_rs),
		.id_rt_o        (id_rt)
	);

	hazard_unit u_hazard (
		.id_rs_i         (id_rs),
		.id_rt_i         (id_rt),
		.ex_rs_i         (ex_rs),
		.ex_rt_i         (ex_rt),
		.ex_dst_i        (ex_dst),
		.mem_dst_i       (mem_dst),
		.wb_dst_i        (wb_idx),
		.ex_mem_read_i   (ex_mem_read),
		.mem_reg_write_i (mem_reg_write),
		.wb_reg_write_i  (wb_en),
		.stall_o         (stall),
		.fwd_a_o         (fwd_a),
		.fwd_b_o         (fwd_b)
	);

	execute_unit u_execute (
		.clk             (clk),
		.reset_n         (reset_n),
		.ex_a_i          (ex_a),
		.ex_b_i          (ex_b),
		.ex_imm_i        (ex_imm),
		.ex_dst_i        (ex_dst),
		.ex_reg_write_i  (ex_reg_write),
		.ex_mem_read_i   (ex_mem_read),
		.ex_mem_write_i  (ex_mem_write),
		.ex_use_imm_i    (ex_use_imm),
		.ex_wwd_i        (ex_wwd),
		.ex_hlt_i        (ex_hlt),
		.ex_alu_op_i     (ex_alu_op),
		.fwd_a_i         (fwd_a),
		.fwd_b_i         (fwd_b),
		.wb_data_i       (wb_data),
		.mem_result_o    (mem_result),
		.mem_store_o     (mem_store),
		.mem_dst_o       (mem_dst),
		.mem_reg_write_o (mem_reg_write),
		.mem_read_o      (mem_read),
		.mem_write_o     (mem_write),
		.mem_wwd_o       (mem_wwd),
		.mem_hlt_o       (mem_hlt)
	);

	mem_wb_unit u_mem_wb (
		.clk             (clk),
		.reset_n         (reset_n),
		.mem_result_i    (mem_result),
		.mem_store_i     (mem_store),
		.mem_dst_i       (mem_dst),
		.mem_reg_write_i (mem_reg_write),
		.mem_read_i      (mem_read),
		.mem_write_i     (mem_write),
		.mem_wwd_i       (mem_wwd),
		.mem_hlt_i       (mem_hlt),
		.data_rdata_i    (data_rdata_i),
		.data_read_o     (data_read_o),
		.data_write_o    (data_write_o),
		.data_addr_o     (data_addr_o),
		.data_wdata_o    (data_wdata_o),
		.wb_en_o         (wb_en),
		.wb_idx_o        (wb_idx),
		.wb_data_o       (wb_data),
		.out_valid_o     (out_valid_o),
		.out_data_o      (out_data_o),
		.num_inst_o      (num_inst_o),
		.is_halted_o     (is_halted_o)
	);

endmodule

//--- src/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              stall_i,
	input  logic              if_valid_i,
	input  logic              wb_en_i,
	input  cpu_pkg::word_t    if_instr_i,
	input  cpu_pkg::reg_idx_t wb_idx_i,
	input  cpu_pkg::word_t    wb_data_i,
	output logic              halt_seen_o,
	output cpu_pkg::word_t    ex_a_o,
	output cpu_pkg::word_t    ex_b_o,
	output cpu_pkg::word_t    ex_imm_o,
	output cpu_pkg::reg_idx_t ex_rs_o,
	output cpu_pkg::reg_idx_t ex_rt_o,
	output cpu_pkg::reg_idx_t ex_dst_o,
	output logic              ex_reg_write_o,
	output logic              ex_mem_read_o,
	output logic              ex_mem_write_o,
	output logic              ex_use_imm_o,
	output logic              ex_wwd_o,
	output logic              ex_hlt_o,
	output logic [1:0]        ex_alu_op_o,
	output cpu_pkg::reg_idx_t id_rs_o,
	output cpu_pkg::reg_idx_t id_rt_o
);

	cpu_pkg::instr_u instr;
	cpu_pkg::word_t rs_data;
	cpu_pkg::word_t rt_data;
	cpu_pkg::word_t dec_imm;
	cpu_pkg::reg_idx_t dec_dst;
	logic [1:0] dec_alu_op;
	logic dec_known;
	logic dec_reg_write;
	logic dec_mem_read;
	logic dec_mem_write;
	logic dec_use_imm;
	logic dec_wwd;
	logic dec_hlt;
	logic issue;

	assign instr = if_instr_i;
	assign id_rs_o = instr.r.rs;
	assign id_rt_o = instr.r.rt;

	register_file u_regs (
		.clk         (clk),
		.reset_n     (reset_n),
		.rd_idx_a_i  (instr.r.rs),
		.rd_idx_b_i  (instr.r.rt),
		.wr_idx_i    (wb_idx_i),
		.wr_en_i     (wb_en_i),
		.wr_data_i   (wb_data_i),
		.rd_data_a_o (rs_data),
		.rd_data_b_o (rt_data)
	);

	always_comb begin
		dec_known = 1'b0;
		dec_reg_write = 1'b0;
		dec_mem_read = 1'b0;
		dec_mem_write = 1'b0;
		dec_use_imm = 1'b0;
		dec_wwd = 1'b0;
		dec_hlt = 1'b0;
		dec_alu_op = cpu_pkg::alu_add;
		dec_dst = instr.i.rt;
		// sign-extended by default, for ADI and the memory offsets
		dec_imm = {{8{instr.i.imm[7]}}, instr.i.imm};
		case (instr.r.opcode)
			cpu_pkg::op_rtype: begin
				dec_dst = instr.r.rd;
				dec_known = 1'b1;
				case (instr.r.func)
					cpu_pkg::fn_add: dec_reg_write = 1'b1;
					cpu_pkg::fn_sub: begin
						dec_reg_write = 1'b1;
						dec_alu_op = cpu_pkg::alu_sub;
					end
					cpu_pkg::fn_and: begin
						dec_reg_write = 1'b1;
						dec_alu_op = cpu_pkg::alu_and;
					end
					cpu_pkg::fn_orr: begin
						dec_reg_write = 1'b1;
						dec_alu_op = cpu_pkg::alu_or;
					end
					cpu_pkg::fn_wwd: dec_wwd = 1'b1;
					cpu_pkg::fn_hlt: dec_hlt = 1'b1;
					default: dec_known = 1'b0;
				endcase
			end
			cpu_pkg::op_adi: begin
				dec_known = 1'b1;
				dec_reg_write = 1'b1;
				dec_use_imm = 1'b1;
			end
			cpu_pkg::op_ori: begin
				dec_known = 1'b1;
				dec_reg_write = 1'b1;
				dec_use_imm = 1'b1;
				dec_alu_op = cpu_pkg::alu_or;
				dec_imm = {8'h00, instr.i.imm};
			end
			cpu_pkg::op_lhi: begin
				// AND with an immediate loads the immediate itself
				dec_known = 1'b1;
				dec_reg_write = 1'b1;
				dec_use_imm = 1'b1;
				dec_alu_op = cpu_pkg::alu_and;
				dec_imm = {instr.i.imm, 8'h00};
			end
			cpu_pkg::op_lwd: begin
				dec_known = 1'b1;
				dec_reg_write = 1'b1;
				dec_mem_read = 1'b1;
				dec_use_imm = 1'b1;
			end
			cpu_pkg::op_swd: begin
				dec_known = 1'b1;
				dec_mem_write = 1'b1;
				dec_use_imm = 1'b1;
			end
			default: dec_known = 1'b0;
		endcase
	end

	// anything stalled, invalid, unknown or past HLT goes in as a bubble
	assign issue = if_valid_i && !stall_i && !halt_seen_o && dec_known;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ex_reg_write_o <= 1'b0;
			ex_mem_read_o <= 1'b0;
			ex_mem_write_o <= 1'b0;
			ex_wwd_o <= 1'b0;
			ex_hlt_o <= 1'b0;
			halt_seen_o <= 1'b0;
		end else begin
			ex_reg_write_o <= issue && dec_reg_write;
			ex_mem_read_o <= issue && dec_mem_read;
			ex_mem_write_o <= issue && dec_mem_write;
			ex_wwd_o <= issue && dec_wwd;
			ex_hlt_o <= issue && dec_hlt;
			if (issue && dec_hlt) begin
				halt_seen_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		ex_a_o <= rs_data;
		ex_b_o <= rt_data;
		ex_imm_o <= dec_imm;
		ex_rs_o <= instr.r.rs;
		ex_rt_o <= instr.r.rt;
		ex_dst_o <= dec_dst;
		ex_use_imm_o <= dec_use_imm;
		ex_alu_op_o <= dec_alu_op;
	end

endmodule

//--- src/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
	input  logic              clk,
	input  logic              reset_n,
	input  cpu_pkg::word_t    ex_a_i,
	input  cpu_pkg::word_t    ex_b_i,
	input  cpu_pkg::word_t    ex_imm_i,
	input  cpu_pkg::reg_idx_t ex_dst_i,
	input  logic              ex_reg_write_i,
	input  logic              ex_mem_read_i,
	input  logic              ex_mem_write_i,
	input  logic              ex_use_imm_i,
	input  logic              ex_wwd_i,
	input  logic              ex_hlt_i,
	input  logic [1:0]        ex_alu_op_i,
	input  logic [1:0]        fwd_a_i,
	input  logic [1:0]        fwd_b_i,
	input  cpu_pkg::word_t    wb_data_i,
	output cpu_pkg::word_t    mem_result_o,
	output cpu_pkg::word_t    mem_store_o,
	output cpu_pkg::reg_idx_t mem_dst_o,
	output logic              mem_reg_write_o,
	output logic              mem_read_o,
	output logic              mem_write_o,
	output logic              mem_wwd_o,
	output logic              mem_hlt_o
);

	cpu_pkg::word_t op_a;
	cpu_pkg::word_t fwd_b;
	cpu_pkg::word_t op_b;
	cpu_pkg::word_t alu_res;

	function automatic cpu_pkg::word_t forward(logic [1:0] sel, cpu_pkg::word_t reg_val);
		case (sel)
			cpu_pkg::fwd_mem: return mem_result_o;
			cpu_pkg::fwd_wb: return wb_data_i;
			default: return reg_val;
		endcase
	endfunction

	assign op_a = forward(fwd_a_i, ex_a_i);
	assign fwd_b = forward(fwd_b_i, ex_b_i);
	assign op_b = ex_use_imm_i ? ex_imm_i : fwd_b;

	always_comb begin
		case (ex_alu_op_i)
			cpu_pkg::alu_add: alu_res = op_a + op_b;
			cpu_pkg::alu_sub: alu_res = op_a - op_b;
			// immediate form is LHI
			cpu_pkg::alu_and: alu_res = ex_use_imm_i ? op_b : (op_a & op_b);
			default: alu_res = op_a | op_b;
		endcase
		// WWD carries rs through unchanged
		if (ex_wwd_i) begin
			alu_res = op_a;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			mem_reg_write_o <= 1'b0;
			mem_read_o <= 1'b0;
			mem_write_o <= 1'b0;
			mem_wwd_o <= 1'b0;
			mem_hlt_o <= 1'b0;
		end else begin
			mem_reg_write_o <= ex_reg_write_i;
			mem_read_o <= ex_mem_read_i;
			mem_write_o <= ex_mem_write_i;
			mem_wwd_o <= ex_wwd_i;
			mem_hlt_o <= ex_hlt_i;
		end
	end

	always_ff @(posedge clk) begin
		mem_result_o <= alu_res;
		mem_store_o <= fwd_b;
		mem_dst_o <= ex_dst_i;
	end

endmodule

//--- src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
	parameter cpu_pkg::word_t reset_pc = 16'h0000
) (
	input  logic           clk,
	input  logic           reset_n,
	input  logic           stall_i,
	input  logic           halt_seen_i,
	input  cpu_pkg::word_t inst_data_i,
	output logic           inst_read_o,
	output cpu_pkg::word_t inst_addr_o,
	output cpu_pkg::word_t if_instr_o,
	output logic           if_valid_o
);

	cpu_pkg::word_t pc;

	// first fetch in the first cycle out of reset
	assign inst_read_o = reset_n && !halt_seen_i;
	assign inst_addr_o = pc;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= reset_pc;
			if_valid_o <= 1'b0;
		end else if (halt_seen_i) begin
			// nothing past HLT may enter decode
			if_valid_o <= 1'b0;
		end else if (!stall_i) begin
			if_valid_o <= 1'b1;
			pc <= pc + 16'd1;
		end
	end

	// fetched word stays put with valid on a stall
	always_ff @(posedge clk) begin
		if (!stall_i && !halt_seen_i) begin
			if_instr_o <= inst_data_i;
		end
	end

endmodule

//--- src/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
	input  cpu_pkg::reg_idx_t id_rs_i,
	input  cpu_pkg::reg_idx_t id_rt_i,
	input  cpu_pkg::reg_idx_t ex_rs_i,
	input  cpu_pkg::reg_idx_t ex_rt_i,
	input  cpu_pkg::reg_idx_t ex_dst_i,
	input  cpu_pkg::reg_idx_t mem_dst_i,
	input  cpu_pkg::reg_idx_t wb_dst_i,
	input  logic              ex_mem_read_i,
	input  logic              mem_reg_write_i,
	input  logic              wb_reg_write_i,
	output logic              stall_o,
	output logic [1:0]        fwd_a_o,
	output logic [1:0]        fwd_b_o
);

	// newest producer wins, so memory stage before writeback
	function automatic logic [1:0] pick_source(cpu_pkg::reg_idx_t src);
		if (mem_reg_write_i && mem_dst_i == src) begin
			return cpu_pkg::fwd_mem;
		end
		if (wb_reg_write_i && wb_dst_i == src) begin
			return cpu_pkg::fwd_wb;
		end
		return cpu_pkg::fwd_reg;
	endfunction

	// load data only exists after the memory stage
	assign stall_o = ex_mem_read_i && (ex_dst_i == id_rs_i || ex_dst_i == id_rt_i);

	assign fwd_a_o = pick_source(ex_rs_i);
	assign fwd_b_o = pick_source(ex_rt_i);

endmodule

//--- src/mem_wb_unit.sv
`timescale 1ns/1ps

module mem_wb_unit (
	input  logic              clk,
	input  logic              reset_n,
	input  cpu_pkg::word_t    mem_result_i,
	input  cpu_pkg::word_t    mem_store_i,
	input  cpu_pkg::reg_idx_t mem_dst_i,
	input  logic              mem_reg_write_i,
	input  logic              mem_read_i,
	input  logic              mem_write_i,
	input  logic              mem_wwd_i,
	input  logic              mem_hlt_i,
	input  cpu_pkg::word_t    data_rdata_i,
	output logic              data_read_o,
	output logic              data_write_o,
	output cpu_pkg::word_t    data_addr_o,
	output cpu_pkg::word_t    data_wdata_o,
	output logic              wb_en_o,
	output cpu_pkg::reg_idx_t wb_idx_o,
	output cpu_pkg::word_t    wb_data_o,
	output logic              out_valid_o,
	output cpu_pkg::word_t    out_data_o,
	output cpu_pkg::word_t    num_inst_o,
	output logic              is_halted_o
);

	logic wb_retire;
	logic wb_hlt;

	// data memory answers in the same cycle
	assign data_read_o = mem_read_i;
	assign data_write_o = mem_write_i;
	assign data_addr_o = mem_result_i;
	assign data_wdata_o = mem_store_i;

	assign out_data_o = wb_data_o;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wb_en_o <= 1'b0;
			wb_retire <= 1'b0;
			wb_hlt <= 1'b0;
			out_valid_o <= 1'b0;
			num_inst_o <= '0;
			is_halted_o <= 1'b0;
		end else begin
			wb_en_o <= mem_reg_write_i;
			// bubbles carry no control bit at all
			wb_retire <= mem_reg_write_i || mem_write_i || mem_wwd_i || mem_hlt_i;
			wb_hlt <= mem_hlt_i;
			out_valid_o <= mem_wwd_i;
			if (wb_retire) begin
				num_inst_o <= num_inst_o + 16'd1;
			end
			if (wb_hlt) begin
				is_halted_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		wb_idx_o <= mem_dst_i;
		wb_data_o <= mem_read_i ? data_rdata_i : mem_result_i;
	end

endmodule

//--- src/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic              clk,
	input  logic              reset_n,
	input  cpu_pkg::reg_idx_t rd_idx_a_i,
	input  cpu_pkg::reg_idx_t rd_idx_b_i,
	input  cpu_pkg::reg_idx_t wr_idx_i,
	input  logic              wr_en_i,
	input  cpu_pkg::word_t    wr_data_i,
	output cpu_pkg::word_t    rd_data_a_o,
	output cpu_pkg::word_t    rd_data_b_o
);

	cpu_pkg::word_t regs [4];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int k = 0; k < 4; k++) begin
				regs[k] <= '0;
			end
		end else if (wr_en_i) begin
			regs[wr_idx_i] <= wr_data_i;
		end
	end

	// same-cycle writeback shows up on the read side
	assign rd_data_a_o = (wr_en_i && wr_idx_i == rd_idx_a_i) ? wr_data_i : regs[rd_idx_a_i];
	assign rd_data_b_o = (wr_en_i && wr_idx_i == rd_idx_b_i) ? wr_data_i : regs[rd_idx_b_i];

endmodule

//--- verification/isa_model.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// xorshift32 step on the shared generator state
function automatic logic [31:0] next_random();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

function automatic cpu_pkg::word_t encode_r(logic [5:0] func, cpu_pkg::reg_idx_t rs,
		cpu_pkg::reg_idx_t rt, cpu_pkg::reg_idx_t rd);
	cpu_pkg::instr_u w;
	w.r.opcode = cpu_pkg::op_rtype;
	w.r.rs = rs;
	w.r.rt = rt;
	w.r.rd = rd;
	w.r.func = func;
	return w;
endfunction

function automatic cpu_pkg::word_t encode_i(logic [3:0] opcode, cpu_pkg::reg_idx_t rs,
		cpu_pkg::reg_idx_t rt, logic [7:0] imm);
	cpu_pkg::instr_u w;
	w.i.opcode = opcode;
	w.i.rs = rs;
	w.i.rt = rt;
	w.i.imm = imm;
	return w;
endfunction

task automatic append_instr(cpu_pkg::word_t w);
	imem[prog_len[7:0]] = w;
	prog_len++;
endtask

// random program whose sources lean on the last destination
task automatic build_program();
	logic [31:0] r;
	cpu_pkg::reg_idx_t rs;
	cpu_pkg::reg_idx_t rt;
	cpu_pkg::reg_idx_t rb;
	cpu_pkg::reg_idx_t last_dst;
	logic [7:0] imm;
	logic [7:0] base;
	logic [7:0] offset;
	last_dst = 2'd0;
	prog_len = 0;
	while (prog_len < 60) begin
		r = next_random();
		rs = (r[7:6] != 2'b00) ? last_dst : r[1:0];
		rt = r[3:2];
		rb = r[23:22];
		imm = r[15:8];
		// small address window so loads often hit earlier stores
		base = {4'b0100, r[25:24], 2'b00};
		offset = {{5{r[10]}}, r[10:8]};
		case (r[18:16])
			3'd0, 3'd1: begin
				append_instr(encode_r({4'b0000, r[21:20]}, rs, r[27] ? last_dst : rt, r[5:4]));
				last_dst = r[5:4];
			end
			3'd2: begin
				append_instr(encode_i(cpu_pkg::op_adi, rs, rt, imm));
				last_dst = rt;
			end
			3'd3: begin
				append_instr(encode_i(cpu_pkg::op_ori, rs, rt, imm));
				last_dst = rt;
			end
			3'd4: begin
				append_instr(encode_i(cpu_pkg::op_lhi, rs, rt, imm));
				last_dst = rt;
			end
			3'd5: begin
				append_instr(encode_i(cpu_pkg::op_lhi, rb, rb, 8'h00));
				append_instr(encode_i(cpu_pkg::op_ori, rb, rb, base));
				append_instr(encode_i(cpu_pkg::op_swd, rb, rs, offset));
				last_dst = rb;
				// read the stored word straight back
				if (r[26]) begin
					append_instr(encode_i(cpu_pkg::op_lwd, rb, rt, offset));
					append_instr(encode_r(cpu_pkg::fn_wwd, rt, 2'd0, 2'd0));
					last_dst = rt;
				end
			end
			3'd6: begin
				append_instr(encode_i(cpu_pkg::op_lhi, rb, rb, 8'h00));
				append_instr(encode_i(cpu_pkg::op_ori, rb, rb, base));
				append_instr(encode_i(cpu_pkg::op_lwd, rb, rt, offset));
				// uses the loaded value right away
				append_instr(encode_r(cpu_pkg::fn_wwd, rt, 2'd0, 2'd0));
				last_dst = rt;
			end
			default: append_instr(encode_r(cpu_pkg::fn_wwd, rs, 2'd0, 2'd0));
		endcase
		if (r[31] && r[18:16] <= 3'd4) begin
			append_instr(encode_r(cpu_pkg::fn_wwd, last_dst, 2'd0, 2'd0));
		end
	end
	append_instr(encode_r(cpu_pkg::fn_hlt, 2'd0, 2'd0, 2'd0));
endtask

// sequential ISA reference model
task automatic run_model();
	cpu_pkg::word_t regs [4];
	cpu_pkg::instr_u w;
	cpu_pkg::word_t sx;
	cpu_pkg::word_t addr;
	regs = '{default: '0};
	retired = '0;
	for (int pc = 0; pc < prog_len; pc++) begin
		w = imem[pc[7:0]];
		sx = {{8{w.i.imm[7]}}, w.i.imm};
		addr = regs[w.i.rs] + sx;
		retired = retired + 16'd1;
		case (w.r.opcode)
			cpu_pkg::op_rtype: begin
				case (w.r.func)
					cpu_pkg::fn_add: regs[w.r.rd] = regs[w.r.rs] + regs[w.r.rt];
					cpu_pkg::fn_sub: regs[w.r.rd] = regs[w.r.rs] - regs[w.r.rt];
					cpu_pkg::fn_and: regs[w.r.rd] = regs[w.r.rs] & regs[w.r.rt];
					cpu_pkg::fn_orr: regs[w.r.rd] = regs[w.r.rs] | regs[w.r.rt];
					cpu_pkg::fn_wwd: exp_out.push_back(regs[w.r.rs]);
					default: ;
				endcase
			end
			cpu_pkg::op_adi: regs[w.i.rt] = regs[w.i.rs] + sx;
			cpu_pkg::op_ori: regs[w.i.rt] = regs[w.i.rs] | {8'h00, w.i.imm};
			cpu_pkg::op_lhi: regs[w.i.rt] = {w.i.imm, 8'h00};
			cpu_pkg::op_lwd: regs[w.i.rt] = model_mem[addr[7:0]];
			cpu_pkg::op_swd: model_mem[addr[7:0]] = regs[w.i.rt];
			default: ;
		endcase
	end
endtask

`endif

//--- verification/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

	logic clk;
	logic reset_n;
	logic inst_read;
	cpu_pkg::word_t inst_addr;
	cpu_pkg::word_t inst_data;
	logic data_read;
	logic data_write;
	cpu_pkg::word_t data_addr;
	cpu_pkg::word_t data_wdata;
	cpu_pkg::word_t data_rdata;
	logic out_valid;
	cpu_pkg::word_t out_data;
	cpu_pkg::word_t num_inst;
	logic is_halted;

	cpu_pkg::word_t imem [256];
	cpu_pkg::word_t dmem [256];
	cpu_pkg::word_t model_mem [256];
	cpu_pkg::word_t exp_out [$];
	cpu_pkg::word_t retired;
	cpu_pkg::word_t expected;
	logic [31:0] rng_state;
	logic halted_prev;
	int prog_len;
	int out_idx;
	int errors;
	int timeouts;
	int cycles;
	int limit;

	`include "isa_model.svh"

	cpu_top #(
		.reset_pc (16'h0000)
	) uut (
		.clk          (clk),
		.reset_n      (reset_n),
		.inst_read_o  (inst_read),
		.inst_addr_o  (inst_addr),
		.inst_data_i  (inst_data),
		.data_read_o  (data_read),
		.data_write_o (data_write),
		.data_addr_o  (data_addr),
		.data_wdata_o (data_wdata),
		.data_rdata_i (data_rdata),
		.out_valid_o  (out_valid),
		.out_data_o   (out_data),
		.num_inst_o   (num_inst),
		.is_halted_o  (is_halted)
	);

	// both memories answer combinationally
	assign inst_data = imem[inst_addr[7:0]];
	// read data only while the core asks for it
	assign data_rdata = data_read ? dmem[data_addr[7:0]] : '0;

	// initial data image built from every address bit
	function automatic cpu_pkg::word_t fill_word(logic [7:0] addr);
		return {addr, ~addr};
	endfunction

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		if (data_write) begin
			dmem[data_addr[7:0]] <= data_wdata;
		end
	end

	// outputs are checked half a cycle after the edge
	always @(negedge clk) begin
		if (!reset_n) begin
			assert (inst_read === 1'b0 && data_read === 1'b0 && data_write === 1'b0 &&
					out_valid === 1'b0 && is_halted === 1'b0 && num_inst === 16'd0)
			else begin
				errors++;
				$display("[ERROR] %0t: DUT outputs active during reset", $time);
			end
		end else begin
			if (out_valid === 1'b1) begin
				expected = (out_idx < exp_out.size()) ? exp_out[out_idx] : 16'hxxxx;
				assert (out_idx < exp_out.size() && out_data === expected) else begin
					errors++;
					$display("[ERROR] %0t: output %0d is %h, expected %h",
							$time, out_idx, out_data, expected);
				end
				out_idx++;
			end
			if (halted_prev) begin
				assert (is_halted === 1'b1 && inst_read === 1'b0 && data_write === 1'b0 &&
						out_valid === 1'b0)
				else begin
					errors++;
					$display("[ERROR] %0t: core active again after halt", $time);
				end
			end else if (is_halted === 1'b1) begin
				assert (num_inst === retired) else begin
					errors++;
					$display("[ERROR] %0t: retired count %0d, expected %0d",
							$time, num_inst, retired);
				end
				assert (out_idx == exp_out.size()) else begin
					errors++;
					$display("[ERROR] %0t: %0d output values at halt, expected %0d",
							$time, out_idx, exp_out.size());
				end
			end
			halted_prev = (is_halted === 1'b1);
		end
	end

	initial begin
		reset_n = 1'b0;
		halted_prev = 1'b0;
		errors = 0;
		timeouts = 0;
		out_idx = 0;
		rng_state = 32'd4;
		for (int a = 0; a < 256; a++) begin
			imem[a[7:0]] = '0;
			dmem[a[7:0]] <= fill_word(a[7:0]);
			model_mem[a[7:0]] = fill_word(a[7:0]);
		end
		build_program();
		run_model();
		limit = 2 * prog_len + 50;
		repeat (10) @(posedge clk);
		reset_n <= 1'b1;
		cycles = 0;
		while (is_halted !== 1'b1 && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (is_halted !== 1'b1) begin
			timeouts++;
			$display("timeout: the core never halted within %0d cycles", limit);
		end else begin
			// watch the halted core for a few more cycles
			repeat (5) @(posedge clk);
			for (int a = 0; a < 256; a++) begin
				assert (dmem[a[7:0]] === model_mem[a[7:0]]) else begin
					errors++;
					$display("[ERROR] %0t: data memory[%0d] is %h, expected %h",
							$time, a, dmem[a[7:0]], model_mem[a[7:0]]);
				end
			end
		end
		$display("summary: %0d check errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
